//--- hdl/rv_pkg.sv
package rv_pkg;

    // ----------------------------------------------------------
    // widths and vector types
    // ----------------------------------------------------------
    localparam int XLEN      = 32;  // integer data path
    localparam int REG_IDX_W = 5;   // x0..x31
    localparam int NUM_REGS  = 32;

    typedef logic [XLEN-1:0]      word_t;     // data or instruction word
    typedef logic [XLEN-1:0]      addr_t;     // byte address
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [2:0]           funct3_t;   // also picks the branch condition
    typedef logic [XLEN/8-1:0]    wstrb_t;    // one bit per byte lane

    localparam addr_t  RESET_PC    = '0;
    localparam addr_t  INSTR_BYTES = 32'd4;   // pc step
    localparam wstrb_t WSTRB_FULL  = 4'b1111; // full word store

    // ----------------------------------------------------------
    // rv32i major opcodes
    // ----------------------------------------------------------
    localparam logic [6:0] OP_LOAD   = 7'b0000011; // lw
    localparam logic [6:0] OP_STORE  = 7'b0100011; // sw
    localparam logic [6:0] OP_IMM    = 7'b0010011; // addi and friends
    localparam logic [6:0] OP_REG    = 7'b0110011; // register-register
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011; // beq..bgeu
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // ----------------------------------------------------------
    // alu operation codes
    // ----------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_SLL  = 4'b0010,
        ALU_SLT  = 4'b0011, // signed compare
        ALU_SLTU = 4'b0100, // unsigned compare
        ALU_XOR  = 4'b0101,
        ALU_SRL  = 4'b0110,
        ALU_SRA  = 4'b0111, // keeps the sign bit
        ALU_OR   = 4'b1000,
        ALU_AND  = 4'b1001
    } alu_op_t;

    // first alu operand
    typedef enum logic [1:0] {
        SRC1_ZERO = 2'd0, // lui
        SRC1_RS1  = 2'd1, // most instructions
        SRC1_PC   = 2'd2  // auipc
    } alu_src1_t;

    // ----------------------------------------------------------
    // instruction stages
    // ----------------------------------------------------------
    typedef enum logic [1:0] {
        ST_FETCH     = 2'd0, // read instruction word at pc
        ST_EXECUTE   = 2'd1, // decode and alu settle
        ST_MEMORY    = 2'd2, // lw / sw only
        ST_WRITEBACK = 2'd3  // register write and pc update
    } stage_t;

endpackage

//--- hdl/rv_decoder.sv
`timescale 1ns/100ps

module rv_decoder (
    input  rv_pkg::word_t     instr,
    output logic              is_load,
    output logic              is_store,
    output logic              is_branch,
    output logic              is_jump,      // jal or jalr
    output logic              is_jalr,
    output logic              reg_write,
    output rv_pkg::alu_src1_t alu_src1,
    output logic              alu_src2_reg, // 1 picks rs2, 0 picks imm
    output rv_pkg::alu_op_t   alu_op,
    output rv_pkg::funct3_t   funct3,
    output rv_pkg::word_t     imm,
    output rv_pkg::reg_idx_t  rs1,
    output rv_pkg::reg_idx_t  rs2,
    output rv_pkg::reg_idx_t  rd
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic       alt_op;  // sub / sra select
    logic [1:0] pre_op;  // 00 add, 01 sub, 10 funct7+funct3, 11 funct3

    // instruction fields
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign alt_op = (funct7 == 7'b0100000);

    // ----------------------------------------------------------
    // control flags
    // ----------------------------------------------------------
    always_comb begin
        is_load      = 1'b0;
        is_store     = 1'b0;
        is_branch    = 1'b0;
        is_jump      = 1'b0;
        is_jalr      = 1'b0;
        reg_write    = 1'b0;
        alu_src1     = SRC1_RS1;
        alu_src2_reg = 1'b0;
        pre_op       = 2'b00; // address and jump forms add
        case (opcode)
            OP_LOAD: begin
                is_load   = 1'b1;
                reg_write = 1'b1;
            end
            OP_STORE:  is_store = 1'b1;
            OP_IMM: begin
                reg_write = 1'b1;
                pre_op    = 2'b11;
            end
            OP_REG: begin
                reg_write    = 1'b1;
                alu_src2_reg = 1'b1;
                pre_op       = 2'b10;
            end
            OP_LUI: begin
                reg_write = 1'b1;
                alu_src1  = SRC1_ZERO; // 0 + imm
            end
            OP_AUIPC: begin
                reg_write = 1'b1;
                alu_src1  = SRC1_PC;   // pc + imm
            end
            OP_BRANCH: begin
                is_branch    = 1'b1;
                alu_src2_reg = 1'b1;
                pre_op       = 2'b01;
            end
            OP_JAL: begin
                is_jump   = 1'b1;
                reg_write = 1'b1;
            end
            OP_JALR: begin
                is_jump   = 1'b1;
                is_jalr   = 1'b1;
                reg_write = 1'b1;
            end
            default: ; // unknown opcode does nothing
        endcase
    end

    // ----------------------------------------------------------
    // alu op from the pre-operation class
    // ----------------------------------------------------------
    always_comb begin
        case (pre_op)
            2'b00: alu_op = ALU_ADD;
            2'b01: alu_op = ALU_SUB;
            default: begin
                case (funct3)
                    3'b000: alu_op = (alt_op && pre_op == 2'b10) ? ALU_SUB : ALU_ADD; // no subi
                    3'b001: alu_op = ALU_SLL;
                    3'b010: alu_op = ALU_SLT;
                    3'b011: alu_op = ALU_SLTU;
                    3'b100: alu_op = ALU_XOR;
                    3'b101: alu_op = alt_op ? ALU_SRA : ALU_SRL;
                    3'b110: alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
            end
        endcase
    end

    // ----------------------------------------------------------
    // immediate generator, all forms sign-extended
    // ----------------------------------------------------------
    always_comb begin
        case (opcode)
            OP_STORE:          imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OP_BRANCH:         imm = {{19{instr[31]}}, instr[31], instr[7],
                                      instr[30:25], instr[11:8], 1'b0};
            OP_LUI, OP_AUIPC:  imm = {instr[31:12], 12'b0};
            OP_JAL:            imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                      instr[20], instr[30:21], 1'b0};
            OP_IMM: begin
                if (funct3 == 3'b001 || funct3 == 3'b101)
                    imm = {27'b0, instr[24:20]}; // shamt only
                else
                    imm = {{20{instr[31]}}, instr[31:20]};
            end
            default:           imm = {{20{instr[31]}}, instr[31:20]}; // i-type
        endcase
    end

endmodule

//--- hdl/rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
    input  rv_pkg::alu_src1_t alu_src1,
    input  logic              alu_src2_reg,
    input  rv_pkg::addr_t     pc,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    input  rv_pkg::word_t     imm,
    input  rv_pkg::alu_op_t   alu_op,
    input  rv_pkg::funct3_t   funct3,
    input  logic              is_branch,
    output rv_pkg::word_t     alu_result,
    output logic              branch_taken
);
    import rv_pkg::*;

    word_t      op1;
    word_t      op2;
    logic [4:0] shamt;     // low five bits only
    logic       cond;

    // operand select
    always_comb begin
        case (alu_src1)
            SRC1_ZERO: op1 = '0;
            SRC1_PC:   op1 = pc;
            default:   op1 = rs1_data;
        endcase
    end
    assign op2   = alu_src2_reg ? rs2_data : imm;
    assign shamt = op2[4:0];

    // ----------------------------------------------------------
    // integer operations
    // ----------------------------------------------------------
    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = op1 + op2;
            ALU_SUB:  alu_result = op1 - op2;
            ALU_SLL:  alu_result = op1 << shamt;
            ALU_SLT:  alu_result = {31'b0, $signed(op1) < $signed(op2)};
            ALU_SLTU: alu_result = {31'b0, op1 < op2};
            ALU_XOR:  alu_result = op1 ^ op2;
            ALU_SRL:  alu_result = op1 >> shamt;
            ALU_SRA:  alu_result = $signed(op1) >>> shamt;
            ALU_OR:   alu_result = op1 | op2;
            ALU_AND:  alu_result = op1 & op2;
            default:  alu_result = '0;
        endcase
    end

    // branch compare straight on the register values
    always_comb begin
        case (funct3)
            3'b000:  cond = (rs1_data == rs2_data);                  // beq
            3'b001:  cond = (rs1_data != rs2_data);                  // bne
            3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));  // blt
            3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data)); // bge
            3'b110:  cond = (rs1_data < rs2_data);                   // bltu
            3'b111:  cond = (rs1_data >= rs2_data);                  // bgeu
            default: cond = 1'b0;
        endcase
    end
    assign branch_taken = is_branch & cond;

endmodule

//--- hdl/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             we,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    wdata,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);
    import rv_pkg::*;

    word_t regs [NUM_REGS];

    // ----------------------------------------------------------
    // write port
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin // x0 never written
            regs[rd] <= wdata;
        end
    end

    // ----------------------------------------------------------
    // async read ports
    // ----------------------------------------------------------
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hdl/rv_control.sv
`timescale 1ns/100ps

module rv_control (
    input  logic           clk,
    input  logic           reset_n,
    // memory port
    input  logic           mem_ready,
    input  rv_pkg::word_t  mem_rdata,
    output logic           mem_valid,
    output logic           mem_instr,
    output rv_pkg::addr_t  mem_addr,
    output rv_pkg::word_t  mem_wdata,
    output rv_pkg::wstrb_t mem_wstrb,
    // decoder flags
    input  logic           is_load,
    input  logic           is_store,
    input  logic           is_branch,
    input  logic           is_jump,
    input  logic           is_jalr,
    input  logic           reg_write,
    // data path
    input  rv_pkg::word_t  alu_result,
    input  logic           branch_taken,
    input  rv_pkg::word_t  imm,
    input  rv_pkg::word_t  rs2_data,    // store data
    output rv_pkg::word_t  instr,
    output rv_pkg::addr_t  pc,
    output logic           rf_we,
    output rv_pkg::word_t  rf_wdata
);
    import rv_pkg::*;

    stage_t stage, stage_next;
    addr_t  pc_next;
    word_t  instr_next;
    word_t  load_data, load_data_next; // lw result held for writeback
    addr_t  pc_plus4;
    logic   mem_stage;

    assign pc_plus4  = pc + INSTR_BYTES;
    assign mem_stage = (stage == ST_MEMORY);

    // ----------------------------------------------------------
    // memory port, all from registered state
    // ----------------------------------------------------------
    assign mem_valid = (stage == ST_FETCH) || mem_stage;
    assign mem_instr = (stage == ST_FETCH);
    assign mem_addr  = (stage == ST_FETCH) ? pc :
                       mem_stage           ? alu_result   // lw / sw address
                                           : '0;
    assign mem_wdata = (mem_stage && is_store) ? rs2_data : '0;
    assign mem_wstrb = (mem_stage && is_store) ? WSTRB_FULL : '0; // zero means read

    // ----------------------------------------------------------
    // writeback
    // ----------------------------------------------------------
    assign rf_we    = (stage == ST_WRITEBACK) && reg_write;
    assign rf_wdata = is_load ? load_data :
                      is_jump ? pc_plus4     // link value
                              : alu_result;

    // ----------------------------------------------------------
    // stage fsm
    // ----------------------------------------------------------
    always_comb begin
        stage_next     = stage;
        pc_next        = pc;
        instr_next     = instr;
        load_data_next = load_data;
        case (stage)
            ST_FETCH: begin
                if (mem_ready) begin
                    instr_next = mem_rdata;
                    stage_next = ST_EXECUTE;
                end
            end
            ST_EXECUTE: begin
                stage_next = (is_load || is_store) ? ST_MEMORY : ST_WRITEBACK;
            end
            ST_MEMORY: begin
                if (mem_ready) begin
                    load_data_next = mem_rdata; // don't care for sw
                    stage_next     = ST_WRITEBACK;
                end
            end
            default: begin // writeback
                if (is_jalr)
                    pc_next = alu_result & ~32'd1;     // clear bit zero
                else if (is_jump || (is_branch && branch_taken))
                    pc_next = pc + imm;                // taken branch or jal
                else
                    pc_next = pc_plus4;
                stage_next = ST_FETCH;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            stage <= ST_FETCH;
            pc    <= RESET_PC;
        end else begin
            stage <= stage_next;
            pc    <= pc_next;
        end
    end

    // instruction and load data registers
    always_ff @(posedge clk) begin
        instr     <= instr_next;
        load_data <= load_data_next;
    end

endmodule

//--- hdl/rv_core.sv
`timescale 1ns/100ps

module rv_core (
    input  logic           clk,
    input  logic           reset_n,
    // memory port
    output logic           mem_valid,
    output logic           mem_instr,   // high on fetches
    input  logic           mem_ready,
    output rv_pkg::addr_t  mem_addr,
    output rv_pkg::word_t  mem_wdata,
    output rv_pkg::wstrb_t mem_wstrb,
    input  rv_pkg::word_t  mem_rdata,
    output rv_pkg::addr_t  peek         // current pc
);
    import rv_pkg::*;

    // ----------------------------------------------------------
    // internal wires
    // ----------------------------------------------------------
    word_t     instr, imm, alu_result, rf_wdata;
    word_t     rs1_data, rs2_data;
    addr_t     pc;
    reg_idx_t  rs1, rs2, rd;
    funct3_t   funct3;
    alu_op_t   alu_op;
    alu_src1_t alu_src1;
    logic      alu_src2_reg, branch_taken, rf_we;
    logic      is_load, is_store, is_branch, is_jump, is_jalr, reg_write;

    assign peek = pc;

    rv_control i_control (
        .clk, .reset_n,
        .mem_ready, .mem_rdata, .mem_valid, .mem_instr,
        .mem_addr, .mem_wdata, .mem_wstrb,
        .is_load, .is_store, .is_branch, .is_jump, .is_jalr, .reg_write,
        .alu_result, .branch_taken, .imm, .rs2_data,
        .instr, .pc, .rf_we, .rf_wdata
    );

    rv_decoder i_decoder (
        .instr,
        .is_load, .is_store, .is_branch, .is_jump, .is_jalr, .reg_write,
        .alu_src1, .alu_src2_reg, .alu_op, .funct3, .imm,
        .rs1, .rs2, .rd
    );

    rv_regfile i_regfile (
        .clk, .reset_n,
        .we    (rf_we),
        .rs1, .rs2, .rd,
        .wdata (rf_wdata),
        .rs1_data, .rs2_data
    );

    rv_alu i_alu (
        .alu_src1, .alu_src2_reg, .pc,
        .rs1_data, .rs2_data, .imm,
        .alu_op, .funct3, .is_branch,
        .alu_result, .branch_taken
    );

endmodule

//--- verif/rv_core_assert.sv
`timescale 1ns/100ps

module rv_core_assert (
    input logic            clk,
    input logic            reset_n,
    input logic            mem_valid,
    input logic            mem_ready,
    input logic            mem_instr,
    input rv_pkg::addr_t   mem_addr,
    input rv_pkg::word_t   mem_wdata,
    input rv_pkg::wstrb_t  mem_wstrb,
    input rv_pkg::word_t   instr,
    input rv_pkg::stage_t  stage
);
    import rv_pkg::*;

    // request held until accepted
    a_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_addr) &&
            $stable(mem_wdata) && $stable(mem_wstrb) && $stable(mem_instr)))
        else $error("memory request changed while waiting");

    // strobe only for a data access of a held sw word
    a_strb: assert property (@(posedge clk) disable iff (!reset_n)
        (mem_wstrb != '0) |-> (!mem_instr && instr[6:0] == OP_STORE))
        else $error("write strobe outside a store");

    // every writeback is followed by a fetch request
    a_fetch: assert property (@(posedge clk) disable iff (!reset_n)
        (stage == ST_WRITEBACK) |=> (stage == ST_FETCH && mem_valid && mem_instr))
        else $error("no fetch request after writeback");

endmodule

bind rv_control rv_core_assert i_assert (
    .clk, .reset_n, .mem_valid, .mem_ready, .mem_instr,
    .mem_addr, .mem_wdata, .mem_wstrb, .instr, .stage
);

//--- verif/tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core;
    import rv_pkg::*;

    // ----------------------------------------------------------
    // constants
    // ----------------------------------------------------------
    localparam int    MEM_WORDS   = 256;       // 1 KiB model
    localparam int    VEC_WORDS   = 128;
    localparam int    EXP_BASE    = 64;        // first expected pair in the vector file
    localparam int    NUM_INSTR   = 47;        // program length in words
    localparam int    PEEK_CYCLES = 20;
    localparam int    CYCLE_LIMIT = NUM_INSTR * 4 * 4 + PEEK_CYCLES + 100;
    localparam addr_t BOOT_ADDR   = 32'h0000_0000; // first fetch after reset
    localparam addr_t DONE_ADDR   = 32'h0000_03f0;
    localparam addr_t LOOP_ADDR   = 32'h0000_00b8; // jal x0,0
    localparam word_t END_MARK    = 32'hffff_ffff;

    logic   clk;
    logic   reset_n;
    logic   mem_valid;
    logic   mem_instr;
    logic   mem_ready;
    addr_t  mem_addr;
    word_t  mem_wdata;
    wstrb_t mem_wstrb;
    word_t  mem_rdata;
    addr_t  peek;

    word_t  vec [0:VEC_WORDS-1];  // program, then expected store pairs
    word_t  mem [0:MEM_WORDS-1];
    int     seed = 32'h74bc;
    int     wait_cnt;             // -1 means no request being served
    int     store_idx;
    int     cycle_count;
    int     error_count;
    logic   done_seen;
    logic   in_reset;             // reset level seen on the last edge

    rv_core i_dut (
        .clk, .reset_n,
        .mem_valid, .mem_instr, .mem_ready,
        .mem_addr, .mem_wdata, .mem_wstrb, .mem_rdata,
        .peek
    );

    // ----------------------------------------------------------
    // error handling and compare tasks
    // ----------------------------------------------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            error_count++;
            $display("ERR %s expected %08h actual %08h", name, exp, act);
            stop_run("address mismatch");
        end
    endtask

    task automatic check_data(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            error_count++;
            $display("ERR %s expected %08h actual %08h", name, exp, act);
            stop_run("data mismatch");
        end
    endtask

    task automatic check_strb(input string name, input wstrb_t exp, input wstrb_t act);
        if (act !== exp) begin
            error_count++;
            $display("ERR %s expected %h actual %h", name, exp, act);
            stop_run("write strobe mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            error_count++;
            $display("ERR %s expected %b actual %b", name, exp, act);
            stop_run("control flag mismatch");
        end
    endtask

    // ----------------------------------------------------------
    // clock, reset, cycle limit
    // ----------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT)
            stop_run("timeout: program did not reach its final loop in time");
    end

    // ----------------------------------------------------------
    // memory model, ready and read data driven after the edge
    // ----------------------------------------------------------
    always @(posedge clk) begin
        in_reset = !reset_n;  // same level the dut used on this edge
        #1;
        if (in_reset) begin
            mem_ready = 1'b0;
            wait_cnt  = -1;
        end else if (mem_valid) begin
            if (wait_cnt < 0)
                wait_cnt = $random(seed) & 32'h3; // new request, 0..3 waits
            if (wait_cnt == 0) begin
                mem_ready = 1'b1;
                mem_rdata = mem[mem_addr[9:2]];
                wait_cnt  = -1;                    // completes on next edge
            end else begin
                mem_ready = 1'b0;
                wait_cnt--;
            end
        end else begin
            mem_ready = 1'b0;
        end
    end

    // stores observed mid-cycle, outputs are stable there
    always @(negedge clk) begin
        if (reset_n && mem_valid && mem_ready && mem_wstrb != '0) begin
            if (vec[EXP_BASE + 2*store_idx] === END_MARK)
                stop_run("store seen after the expected list ended");
            check_addr($sformatf("store %0d addr", store_idx),
                       vec[EXP_BASE + 2*store_idx], mem_addr);
            check_data($sformatf("store %0d data", store_idx),
                       vec[EXP_BASE + 2*store_idx + 1], mem_wdata);
            check_strb($sformatf("store %0d strb", store_idx), WSTRB_FULL, mem_wstrb);
            check_flag($sformatf("store %0d instr", store_idx), 1'b0, mem_instr);
            mem[mem_addr[9:2]] = mem_wdata;
            if (mem_addr == DONE_ADDR)
                done_seen = 1'b1;
            store_idx++;
        end
    end

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------
    initial begin
        reset_n     = 1'b0;
        mem_ready   = 1'b0;
        mem_rdata   = '0;
        wait_cnt    = -1;
        store_idx   = 0;
        cycle_count = 0;
        error_count = 0;
        done_seen   = 1'b0;
        $readmemh("verif/rv_core_vectors.txt", vec);
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = i * 32'h9e37_79b1;  // filler from the full word index
        end
        for (int i = 0; i < NUM_INSTR; i++) begin
            mem[i] = vec[i];
        end

        repeat (2) @(posedge clk);
        #1 reset_n = 1'b1;

        // first cycle out of reset is a fetch at the boot address
        @(negedge clk);
        check_flag("boot fetch valid", 1'b1, mem_valid);
        check_flag("boot fetch instr", 1'b1, mem_instr);
        check_addr("boot fetch addr", BOOT_ADDR, mem_addr);
        check_strb("boot fetch strb", 4'b0000, mem_wstrb);

        wait (done_seen);
        while (peek !== LOOP_ADDR) @(negedge clk);  // cycle limit guards this
        repeat (PEEK_CYCLES) begin
            @(negedge clk);
            check_addr("peek loop", LOOP_ADDR, peek);
        end
        if (vec[EXP_BASE + 2*store_idx] !== END_MARK)
            stop_run("expected stores left over at the end of the program");

        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verif/rv_core_vectors.txt
// words 0x00..0x2e: program, one instruction per line
// from @40: expected stores as address then data, ffffffff ends the list
20000093 // addi x1,x0,0x200
00700113 // addi x2,x0,7
FFD00193 // addi x3,x0,-3
00310233 // add  x4,x2,x3
0040A023 // sw   x4,0(x1)
403102B3 // sub  x5,x2,x3
0050A223 // sw   x5,4(x1)
00211333 // sll  x6,x2,x2
4021D3B3 // sra  x7,x3,x2
00734333 // xor  x6,x6,x7
0060A423 // sw   x6,8(x1)
0021A433 // slt  x8,x3,x2
0021B4B3 // sltu x9,x3,x2
01C1D513 // srli x10,x3,28
00841593 // slli x11,x8,8
00B56533 // or   x10,x10,x11
00510013 // addi x0,x2,5
00050533 // add  x10,x10,x0
00A0A623 // sw   x10,12(x1)
0040A603 // lw   x12,4(x1)
00C0A823 // sw   x12,16(x1)
123456B7 // lui  x13,0x12345
00001717 // auipc x14,1
00E686B3 // add  x13,x13,x14
00D0AA23 // sw   x13,20(x1)
00210463 // beq  x2,x2,+8
00178793 // addi x15,x15,1
00211463 // bne  x2,x2,+8
00278793 // addi x15,x15,2
0021C463 // blt  x3,x2,+8
00478793 // addi x15,x15,4
0021D463 // bge  x3,x2,+8
00878793 // addi x15,x15,8
0021E463 // bltu x3,x2,+8
01078793 // addi x15,x15,16
0021F463 // bgeu x3,x2,+8
02078793 // addi x15,x15,32
00F0AC23 // sw   x15,24(x1)
0080086F // jal  x16,+8
FFF00813 // addi x16,x0,-1
0100AE23 // sw   x16,28(x1)
0B100893 // addi x17,x0,0xb1
00088967 // jalr x18,0(x17)
FFF00913 // addi x18,x0,-1
0320A023 // sw   x18,32(x1)
1E20A823 // sw   x2,0x1f0(x1)
0000006F // jal  x0,0
@40
00000200 00000004
00000204 0000000A
00000208 FFFFFC7F
0000020C 0000010F
00000210 0000000A
00000214 12346058
00000218 0000001A
0000021C 0000009C
00000220 000000AC
000003F0 00000007
FFFFFFFF

//--- rv_core.f
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_control.sv
hdl/rv_core.sv
verif/rv_core_assert.sv
verif/tb_rv_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv_core.f --top-module tb_rv_core

./obj_dir/Vtb_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    exit 1
fi
exit 0
